// File: hdl/qracc_pkg.sv
package qracc_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int N_LANES   = 16;    // Activation lanes per word
    localparam int ACT_BITS  = 8;     // Bits per activation
    localparam int CSR_WIDTH = 32;

    // Column ADC code limits, signed 5-bit
    localparam int ADC_MAX = 15;
    localparam int ADC_MIN = -16;

    // Register map
    localparam logic [2:0] CSR_MAIN   = 3'd0;
    localparam logic [2:0] CSR_CONFIG = 3'd1;
    localparam logic [2:0] CSR_STATUS = 3'd2;   // Result on read, weights on write
    localparam logic [2:0] CSR_ACT0   = 3'd4;   // First of four activation words

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [CSR_WIDTH-1:0]        csr_data_t;
    typedef logic [N_LANES-1:0]          lane_mask_t;
    typedef logic [N_LANES*ACT_BITS-1:0] act_vec_t;     // Lane j at [8j+7:8j]
    typedef logic [2:0]                  bit_idx_t;
    typedef logic [4:0]                  col_sum_t;     // 0 to 16
    typedef logic signed [4:0]           adc_code_t;
    typedef logic signed [CSR_WIDTH-1:0] acc_t;

    typedef struct packed {
        logic [2:0] adc_ref_range_shifts;   // ADC range as right shift
        logic       binary_cfg;             // 1 unsigned, 0 two's complement
        logic [2:0] n_input_bits_cfg;       // Slices minus one
    } qracc_config_t;

    typedef struct packed {
        logic       valid;
        bit_idx_t   bit_idx;
        logic       last;
        lane_mask_t bits;
    } slice_t;

    typedef struct packed {
        logic     valid;
        bit_idx_t bit_idx;
        logic     last;
        col_sum_t sum;
    } col_out_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_t;

endpackage

// File: hdl/csr.sv
module csr #(
    parameter int numCsr = 8
) (
    input  logic                  clk,
    input  logic                  nrst,

    input  qracc_pkg::csr_data_t  csr_data_i,
    input  logic                  csr_wr_en_i,
    input  logic                  csr_rd_en_i,
    input  logic [2:0]            csr_addr_i,
    output qracc_pkg::csr_data_t  csr_data_o,

    input  logic                  busy_i,
    input  qracc_pkg::acc_t       result_i,

    output qracc_pkg::qracc_config_t cfg_o,
    output qracc_pkg::act_vec_t   acts_o,
    output logic                  start_o,
    output logic                  clear_o,
    output logic                  wgt_wr_o
);

    import qracc_pkg::*;

    ////////////////////////////////////////
    // Register array
    ////////////////////////////////////////

    csr_data_t csr_q [numCsr];
    logic      store_en;
    logic      inst_write_mode;

    // STATUS and address 3 hold nothing
    assign store_en = csr_wr_en_i &&
                      (csr_addr_i == CSR_MAIN ||
                       csr_addr_i == CSR_CONFIG ||
                       csr_addr_i >= CSR_ACT0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < numCsr; i++) begin
                csr_q[i] <= '0;
            end
        end else if (store_en) begin
            csr_q[csr_addr_i] <= csr_data_i;
        end
    end

    assign inst_write_mode = csr_q[CSR_MAIN][3];

    ////////////////////////////////////////
    // Read decode
    ////////////////////////////////////////

    always_comb begin
        csr_data_o = '0;
        if (csr_rd_en_i) begin
            case (csr_addr_i)
                CSR_MAIN: begin
                    csr_data_o[3] = inst_write_mode;
                    csr_data_o[1] = busy_i;
                end
                CSR_CONFIG: csr_data_o = csr_q[CSR_CONFIG];
                CSR_STATUS: csr_data_o = result_i;
                default: begin
                    // Activation words, address 3 stays zero
                    if (csr_addr_i >= CSR_ACT0) begin
                        csr_data_o = csr_q[csr_addr_i];
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////

    always_comb begin
        start_o  = 1'b0;
        clear_o  = 1'b0;
        wgt_wr_o = 1'b0;
        if (csr_wr_en_i && csr_addr_i == CSR_MAIN) begin
            start_o = csr_data_i[0];
            clear_o = csr_data_i[1];
        end
        // Weight planes only in instruction-write mode
        if (csr_wr_en_i && csr_addr_i == CSR_STATUS) begin
            wgt_wr_o = inst_write_mode;
        end
    end

    // Configuration fields
    assign cfg_o.n_input_bits_cfg     = csr_q[CSR_CONFIG][2:0];
    assign cfg_o.binary_cfg           = csr_q[CSR_CONFIG][3];
    assign cfg_o.adc_ref_range_shifts = csr_q[CSR_CONFIG][6:4];

    // Four lanes per word, low lane in low byte
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            acts_o[w*CSR_WIDTH +: CSR_WIDTH] = csr_q[CSR_ACT0 + w];
        end
    end

endmodule

// File: hdl/qracc_ctrl.sv
module qracc_ctrl (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     start_i,
    input  logic                     clear_i,
    input  qracc_pkg::qracc_config_t cfg_i,
    input  qracc_pkg::act_vec_t      acts_i,
    output qracc_pkg::slice_t        slice_o,
    output logic                     busy_o,
    output logic                     done_o
);

    import qracc_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    bit_idx_t    cnt_q;
    logic        last_slice;

    assign last_slice = (cnt_q == cfg_i.n_input_bits_cfg);

    ////////////////////////////////////////
    // Run FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = RUN;     // Start ignored unless idle
            RUN:     if (last_slice) state_d = DRAIN;
            DRAIN:   state_d = IDLE;                 // Last term lands in accumulator
            default: state_d = IDLE;
        endcase
        if (clear_i) begin
            state_d = IDLE;                          // Abort, no done
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == DRAIN) && !clear_i;
            if (state_q == RUN && !last_slice) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    assign busy_o = (state_q != IDLE);

    ////////////////////////////////////////
    // Bit-slice gather
    ////////////////////////////////////////

    always_comb begin
        slice_o.valid   = (state_q == RUN);
        slice_o.bit_idx = cnt_q;
        slice_o.last    = last_slice;
        for (int j = 0; j < N_LANES; j++) begin
            slice_o.bits[j] = acts_i[j*ACT_BITS + int'(cnt_q)];   // Bit k of lane j
        end
    end

endmodule

// File: hdl/column_sum.sv
module column_sum (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  clear_i,
    input  logic                  wgt_wr_i,
    input  qracc_pkg::lane_mask_t wgt_i,
    input  qracc_pkg::slice_t     slice_i,
    output qracc_pkg::col_out_t   col_o
);

    import qracc_pkg::*;

    lane_mask_t wgt_q;
    lane_mask_t hits;
    col_sum_t   count;

    // One row of weight bits
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wgt_q <= '0;
        end else if (clear_i) begin
            wgt_q <= '0;
        end else if (wgt_wr_i) begin
            wgt_q <= wgt_i;
        end
    end

    // Lanes where activation bit and weight are both 1
    assign hits = slice_i.bits & wgt_q;

    always_comb begin
        count = '0;
        for (int j = 0; j < N_LANES; j++) begin
            count = count + col_sum_t'(hits[j]);
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            col_o <= '0;
        end else begin
            col_o.valid   <= slice_i.valid && !clear_i;   // Drop in-flight slice on clear
            col_o.bit_idx <= slice_i.bit_idx;
            col_o.last    <= slice_i.last;
            col_o.sum     <= count;
        end
    end

endmodule

// File: hdl/shift_accumulator.sv
module shift_accumulator (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     clear_i,
    input  qracc_pkg::qracc_config_t cfg_i,
    input  qracc_pkg::col_out_t      pos_i,
    input  qracc_pkg::col_out_t      neg_i,
    output qracc_pkg::acc_t          result_o
);

    import qracc_pkg::*;

    logic signed [5:0] diff;       // -16 to 16
    logic signed [5:0] shifted;
    adc_code_t         code;
    acc_t              term;
    acc_t              signed_term;
    logic              pair_valid;
    logic              sub_term;

    assign pair_valid = pos_i.valid && neg_i.valid;

    ////////////////////////////////////////
    // Column ADC model
    ////////////////////////////////////////

    always_comb begin
        diff    = $signed({1'b0, pos_i.sum}) - $signed({1'b0, neg_i.sum});
        shifted = diff >>> cfg_i.adc_ref_range_shifts;

        // Saturate to signed 5-bit
        if (shifted > ADC_MAX) begin
            code = adc_code_t'(ADC_MAX);
        end else if (shifted < ADC_MIN) begin
            code = adc_code_t'(ADC_MIN);
        end else begin
            code = adc_code_t'(shifted);
        end
    end

    ////////////////////////////////////////
    // Shift-add
    ////////////////////////////////////////

    always_comb begin
        term     = acc_t'(code) <<< pos_i.bit_idx;        // Weight by slice position
        sub_term = !cfg_i.binary_cfg && pos_i.last;       // Sign slice in two's complement
        if (sub_term) begin
            signed_term = -term;
        end else begin
            signed_term = term;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result_o <= '0;
        end else if (clear_i) begin
            result_o <= '0;
        end else if (pair_valid) begin
            if (pos_i.bit_idx == '0) begin
                result_o <= signed_term;                  // First slice restarts the sum
            end else begin
                result_o <= result_o + signed_term;
            end
        end
    end

endmodule

// File: hdl/qracc_top.sv
module qracc_top (
    input  logic                 clk,
    input  logic                 nrst,
    input  qracc_pkg::csr_data_t csr_data_i,
    input  logic                 csr_wr_en_i,
    input  logic                 csr_rd_en_i,
    input  logic [2:0]           csr_addr_i,
    output qracc_pkg::csr_data_t csr_data_o,
    output logic                 done_o
);

    import qracc_pkg::*;

    qracc_config_t cfg;
    act_vec_t      acts;
    slice_t        slice;
    col_out_t      col_pos;
    col_out_t      col_neg;
    acc_t          result;
    logic          start;
    logic          clear;
    logic          wgt_wr;
    logic          busy;

    ////////////////////////////////////////
    // Host side
    ////////////////////////////////////////

    csr u_csr (
        .clk         (clk),
        .nrst        (nrst),
        .csr_data_i  (csr_data_i),
        .csr_wr_en_i (csr_wr_en_i),
        .csr_rd_en_i (csr_rd_en_i),
        .csr_addr_i  (csr_addr_i),
        .csr_data_o  (csr_data_o),
        .busy_i      (busy),
        .result_i    (result),
        .cfg_o       (cfg),
        .acts_o      (acts),
        .start_o     (start),
        .clear_o     (clear),
        .wgt_wr_o    (wgt_wr)
    );

    qracc_ctrl u_ctrl (
        .clk     (clk),
        .nrst    (nrst),
        .start_i (start),
        .clear_i (clear),
        .cfg_i   (cfg),
        .acts_i  (acts),
        .slice_o (slice),
        .busy_o  (busy),
        .done_o  (done_o)
    );

    ////////////////////////////////////////
    // Compute path
    ////////////////////////////////////////

    column_sum u_col_pos (
        .clk      (clk),
        .nrst     (nrst),
        .clear_i  (clear),
        .wgt_wr_i (wgt_wr),
        .wgt_i    (csr_data_i[N_LANES-1:0]),            // Low half, positive plane
        .slice_i  (slice),
        .col_o    (col_pos)
    );

    column_sum u_col_neg (
        .clk      (clk),
        .nrst     (nrst),
        .clear_i  (clear),
        .wgt_wr_i (wgt_wr),
        .wgt_i    (csr_data_i[2*N_LANES-1:N_LANES]),    // High half, negative plane
        .slice_i  (slice),
        .col_o    (col_neg)
    );

    shift_accumulator u_acc (
        .clk      (clk),
        .nrst     (nrst),
        .clear_i  (clear),
        .cfg_i    (cfg),
        .pos_i    (col_pos),
        .neg_i    (col_neg),
        .result_o (result)
    );

endmodule

// File: verification/tb_qracc.sv
module tb_qracc;

    import qracc_pkg::*;

    localparam int N_TESTS    = 6;
    localparam int CLK_PERIOD = 10;

    logic       clk;
    logic       nrst;
    csr_data_t  csr_data_i;
    logic       csr_wr_en_i;
    logic       csr_rd_en_i;
    logic [2:0] csr_addr_i;
    csr_data_t  csr_data_o;
    logic       done_o;

    logic [7:0] act_q [N_LANES];   // Host copy of the activations
    lane_mask_t pos_w;
    lane_mask_t neg_w;
    acc_t       expected;
    csr_data_t  rnd_word;
    int         exp_busy;
    logic       len_check;         // Off while a run is aborted
    int         busy_cycles;
    int         done_seen;
    int         done_before;
    int         errors;
    int         test_start;
    int         failed_tests;

    qracc_top u_qracc_top (
        .clk         (clk),
        .nrst        (nrst),
        .csr_data_i  (csr_data_i),
        .csr_wr_en_i (csr_wr_en_i),
        .csr_rd_en_i (csr_rd_en_i),
        .csr_addr_i  (csr_addr_i),
        .csr_data_o  (csr_data_o),
        .done_o      (done_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy_cycles <= 0;
            done_seen   <= 0;
        end else begin
            busy_cycles <= u_qracc_top.busy ? busy_cycles + 1 : 0;
            if (done_o) done_seen <= done_seen + 1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!nrst)
        done_o |-> !u_qracc_top.busy ##1 !done_o)
    else begin
        $display("done_o was not a single cycle pulse with busy low");
        errors++;
    end

    assert property (@(posedge clk) disable iff (!nrst)
        done_o |-> csr_data_o == expected)
    else begin
        $display("Error: csr_data_o = %h, expected %h", $sampled(csr_data_o), expected);
        errors++;
    end

    // Busy spans one cycle per slice plus the drain cycle
    assert property (@(posedge clk) disable iff (!nrst)
        ($fell(u_qracc_top.busy) && len_check) |-> busy_cycles == exp_busy)
    else begin
        $display("Error: busy length = %h, expected %h", $sampled(busy_cycles), exp_busy);
        errors++;
    end

    ////////////////////////////////////////
    // Reference model and bus tasks
    ////////////////////////////////////////

    function automatic acc_t model_result(input int n, input logic binary, input int shift);
        int   pc;
        int   nc;
        int   code;
        acc_t res;
        res = 0;
        for (int k = 0; k <= n; k++) begin
            pc = 0;
            nc = 0;
            for (int j = 0; j < N_LANES; j++) begin
                pc += act_q[j][k] & pos_w[j];
                nc += act_q[j][k] & neg_w[j];
            end
            code = (pc - nc) >>> shift;
            if (code > 15) code = 15;              // Column ADC clips
            else if (code < -16) code = -16;
            if (!binary && k == n) res -= code * (1 << k);   // Sign slice
            else res += code * (1 << k);
        end
        return res;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [2:0] addr, input csr_data_t data);
        csr_wr_en_i = 1'b1;
        csr_addr_i  = addr;
        csr_data_i  = data;
        tick();
        csr_wr_en_i = 1'b0;
    endtask

    task automatic check_read(input logic [2:0] addr, input csr_data_t exp);
        csr_rd_en_i = 1'b1;
        csr_addr_i  = addr;
        #1;
        assert (csr_data_o == exp) else begin
            $display("Error: csr_data_o at %0d = %h, expected %h", addr, csr_data_o, exp);
            errors++;
        end
        csr_rd_en_i = 1'b0;
        tick();
    endtask

    task automatic new_operands();
        for (int j = 0; j < N_LANES; j++) act_q[j] = 8'($urandom);
        pos_w = lane_mask_t'($urandom);
        neg_w = lane_mask_t'($urandom);
    endtask

    task automatic setup_run(input int n, input logic binary, input int shift, input logic load_w);
        csr_data_t word;
        bus_write(CSR_CONFIG, csr_data_t'({shift[2:0], binary, n[2:0]}));
        for (int w = 0; w < 4; w++) begin
            word = {act_q[4*w+3], act_q[4*w+2], act_q[4*w+1], act_q[4*w]};
            bus_write(3'(CSR_ACT0 + w), word);
        end
        if (load_w) begin
            bus_write(CSR_MAIN, 32'h8);            // Instruction-write mode
            bus_write(CSR_STATUS, {neg_w, pos_w});
            bus_write(CSR_MAIN, 32'h0);
        end
        expected = model_result(n, binary, shift);
        exp_busy = n + 2;                          // n+1 slices and one drain cycle
    endtask

    task automatic start_and_wait(input logic restart);
        int cycles;
        len_check = 1'b1;
        bus_write(CSR_MAIN, 32'h1);
        if (restart) begin
            tick();
            bus_write(CSR_MAIN, 32'h1);            // Lands while busy
        end
        csr_rd_en_i = 1'b1;                        // Hold STATUS for the done check
        csr_addr_i  = CSR_STATUS;
        cycles = 0;
        while (!done_o && cycles < 40) begin
            tick();
            cycles++;
        end
        assert (done_o) else begin
            $display("No done pulse within 40 cycles of start");
            errors++;
        end
        tick();
        csr_rd_en_i = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_start) begin
            $display("Test %0d (%s) passed", num, name);
        end else begin
            $display("Test %0d (%s) failed with %0d errors", num, name, errors - test_start);
            failed_tests++;
        end
        test_start = errors;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        csr_data_i   = '0;
        csr_wr_en_i  = 1'b0;
        csr_rd_en_i  = 1'b0;
        csr_addr_i   = '0;
        len_check    = 1'b0;
        expected     = '0;
        exp_busy     = 0;
        errors       = 0;
        test_start   = 0;
        failed_tests = 0;
        pos_w        = '0;
        neg_w        = '0;
        void'($urandom(81341));
        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;

        for (int a = 0; a < 8; a++) check_read(3'(a), '0);
        bus_write(CSR_CONFIG, 32'hA5A5_0073);
        check_read(CSR_CONFIG, 32'hA5A5_0073);
        for (int w = 0; w < 4; w++) begin
            rnd_word = $urandom;
            bus_write(3'(CSR_ACT0 + w), rnd_word);
            check_read(3'(CSR_ACT0 + w), rnd_word);
        end
        bus_write(3'd3, 32'hFFFF_FFFF);            // Address 3 holds nothing
        check_read(3'd3, '0);
        end_test(1, "reset values and readback");

        new_operands();
        setup_run(7, 1'b1, 0, 1'b1);
        start_and_wait(1'b0);
        end_test(2, "unsigned run");

        repeat (4) begin
            new_operands();
            setup_run($urandom % 8, 1'b0, 0, 1'b1);
            start_and_wait(1'b0);
        end
        end_test(3, "signed runs");

        // Only shift 0 can clip when the full column difference is +16
        for (int j = 0; j < N_LANES; j++) act_q[j] = 8'hFF;
        pos_w = 16'hFFFF;
        neg_w = 16'h0000;
        setup_run(7, 1'b1, 0, 1'b1);
        start_and_wait(1'b0);
        pos_w = 16'h0000;
        neg_w = 16'hFFFF;
        setup_run(7, 1'b0, 0, 1'b1);
        start_and_wait(1'b0);
        repeat (3) begin
            new_operands();
            pos_w = pos_w | lane_mask_t'($urandom);
            setup_run($urandom % 8, 1'($urandom), 1 + $urandom % 7, 1'b1);
            start_and_wait(1'b0);
        end
        end_test(4, "ADC shift and saturation");

        new_operands();
        setup_run(7, 1'b0, 1, 1'b1);
        start_and_wait(1'b1);
        end_test(5, "start while busy");

        new_operands();
        setup_run(7, 1'b1, 0, 1'b1);
        done_before = done_seen;
        bus_write(CSR_MAIN, 32'h1);
        tick();
        len_check = 1'b0;
        bus_write(CSR_MAIN, 32'h2);                // Clear mid-run
        check_read(CSR_MAIN, '0);
        repeat (10) tick();
        assert (done_seen == done_before) else begin
            $display("A done pulse appeared after the run was cleared");
            errors++;
        end
        check_read(CSR_STATUS, '0);
        pos_w = '0;                                 // Planes were zeroed by clear
        neg_w = '0;
        setup_run(7, 1'b1, 0, 1'b0);
        start_and_wait(1'b0);
        end_test(6, "clear during run");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 N_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(N_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

// File: list.f
hdl/qracc_pkg.sv
hdl/csr.sv
hdl/qracc_ctrl.sv
hdl/column_sum.sv
hdl/shift_accumulator.sv
hdl/qracc_top.sv
verification/tb_qracc.sv
